// File: hdl/SchedulerTypes.sv
// Shared sizes and vector types for the issue queue wakeup and select stage.
// Every other file refers to these through SchedulerTypes:: scoped names.
package SchedulerTypes;

    // Issue queue
    localparam int ISSUE_QUEUE_ENTRY_NUM = 8;
    localparam int ISSUE_QUEUE_INDEX_WIDTH = $clog2(ISSUE_QUEUE_ENTRY_NUM);

    // Integer issue lanes first, then the memory lane
    localparam int INT_ISSUE_WIDTH = 2;
    localparam int MEM_ISSUE_WIDTH = 1;
    localparam int ISSUE_WIDTH = INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH;

    // Integer issue lanes plus the external load wakeup
    localparam int WAKEUP_NUM = INT_ISSUE_WIDTH + 1;

    // Physical registers
    localparam int PHY_REG_NUM = 32;
    localparam int PREG_NUM_WIDTH = $clog2(PHY_REG_NUM);

    typedef logic [ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;
    typedef logic [ISSUE_QUEUE_INDEX_WIDTH-1:0] IssueQueueIndexPath;
    typedef logic [PREG_NUM_WIDTH-1:0] PRegNumPath;
    typedef logic [ISSUE_WIDTH-1:0] IssueLaneVector;

    typedef enum logic [0:0] {
        OP_INT = 1'b0,
        OP_MEM = 1'b1
    } OpClass;

endpackage : SchedulerTypes

// File: hdl/WakeupSelectIF.sv
// Connects the wakeup logic, the select logic and the wakeup pipeline register.
// One instance lives in the scheduler top.
interface WakeupSelectIF;

    // Wakeup logic -> select logic
    SchedulerTypes::IssueQueueOneHotPath opReady;
    SchedulerTypes::IssueQueueOneHotPath intIssueReq;
    SchedulerTypes::IssueQueueOneHotPath memIssueReq;
    SchedulerTypes::PRegNumPath entryDstTag [SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM];

    // Select logic -> pipeline register and entry release
    logic selected [SchedulerTypes::ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath selectedPtr [SchedulerTypes::ISSUE_WIDTH];
    SchedulerTypes::IssueQueueOneHotPath selectedVector [SchedulerTypes::ISSUE_WIDTH];

    // Pipeline register -> wakeup broadcast
    SchedulerTypes::IssueLaneVector issueValid;
    SchedulerTypes::PRegNumPath issueDstTag [SchedulerTypes::ISSUE_WIDTH];

    modport WakeupLogic (
        output opReady, intIssueReq, memIssueReq, entryDstTag,
        input selectedVector, issueValid, issueDstTag
    );

    modport SelectLogic (
        input opReady, intIssueReq, memIssueReq,
        output selected, selectedPtr, selectedVector
    );

    modport PipelineRegister (
        input selected, selectedPtr, entryDstTag,
        output issueValid, issueDstTag
    );

endinterface : WakeupSelectIF

// File: hdl/Picker.sv
// Lowest-index-first picker.
// Grant slot k takes the k-th lowest set request; grant is the union of all
// granted requests. Used for the memory lane and for free-entry allocation.
module Picker #(
    parameter int ENTRY_NUM = SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM,
    parameter int GRANT_NUM = 1
)(
    input  SchedulerTypes::IssueQueueOneHotPath req,
    output SchedulerTypes::IssueQueueOneHotPath grant,
    output SchedulerTypes::IssueQueueIndexPath grantPtr [GRANT_NUM],
    output logic granted [GRANT_NUM]
);

    SchedulerTypes::IssueQueueOneHotPath remaining;

    always_comb begin
        remaining = req;
        grant = '0;

        for (int g = 0; g < GRANT_NUM; g++) begin
            granted[g] = 1'b0;
            grantPtr[g] = '0;

            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (!granted[g] && remaining[i]) begin
                    granted[g] = 1'b1;
                    grantPtr[g] = SchedulerTypes::IssueQueueIndexPath'(i);
                end
            end

            // Hide this request from the later slots
            if (granted[g]) begin
                remaining[grantPtr[g]] = 1'b0;
                grant[grantPtr[g]] = 1'b1;
            end
        end
    end

endmodule : Picker

// File: hdl/InterleavedPicker.sv
// Interleaved picker for the integer lanes.
// Slot g only sees requests whose index is congruent to g modulo GRANT_NUM and
// takes the lowest of them. Each slot searches ENTRY_NUM / GRANT_NUM entries,
// so the search is much shallower than a full priority chain.
module InterleavedPicker #(
    parameter int ENTRY_NUM = SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM,
    parameter int GRANT_NUM = SchedulerTypes::INT_ISSUE_WIDTH
)(
    input  SchedulerTypes::IssueQueueOneHotPath req,
    output SchedulerTypes::IssueQueueOneHotPath grant,
    output SchedulerTypes::IssueQueueIndexPath grantPtr [GRANT_NUM],
    output logic granted [GRANT_NUM]
);

    // With 8 entries and 2 grants
    //   slot 0 picks among req[0], req[2], req[4], req[6]
    //   slot 1 picks among req[1], req[3], req[5], req[7]
    always_comb begin
        grant = '0;

        for (int g = 0; g < GRANT_NUM; g++) begin
            granted[g] = 1'b0;
            grantPtr[g] = '0;

            for (int i = g; i < ENTRY_NUM; i += GRANT_NUM) begin
                if (!granted[g] && req[i]) begin
                    granted[g] = 1'b1;
                    grantPtr[g] = SchedulerTypes::IssueQueueIndexPath'(i);
                end
            end

            // Slots never share an index, so no masking between them
            if (granted[g]) begin
                grant[grantPtr[g]] = 1'b1;
            end
        end
    end

endmodule : InterleavedPicker

// File: hdl/SelectLogic.sv
// Select logic of the issue queue.
// Forms the per-class requests, runs the integer and memory pickers and
// drives the flush-masked selection onto the wakeup/select interface.
module SelectLogic (
    WakeupSelectIF.SelectLogic port,
    input SchedulerTypes::IssueQueueOneHotPath flushEntry
);

    SchedulerTypes::IssueQueueOneHotPath intRequest;
    SchedulerTypes::IssueQueueOneHotPath intGrant;
    logic intSelected [SchedulerTypes::INT_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath intSelectedPtr [SchedulerTypes::INT_ISSUE_WIDTH];

    SchedulerTypes::IssueQueueOneHotPath memRequest;
    SchedulerTypes::IssueQueueOneHotPath memGrant;
    logic memSelected [SchedulerTypes::MEM_ISSUE_WIDTH];
    SchedulerTypes::IssueQueueIndexPath memSelectedPtr [SchedulerTypes::MEM_ISSUE_WIDTH];

    // Entries visible to one interleaved integer lane
    SchedulerTypes::IssueQueueOneHotPath laneMask;

    assign intRequest = port.opReady & port.intIssueReq;
    assign memRequest = port.opReady & port.memIssueReq;

    InterleavedPicker #(
        .ENTRY_NUM(SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(SchedulerTypes::INT_ISSUE_WIDTH)
    ) intPicker (
        .req(intRequest),
        .grant(intGrant),
        .grantPtr(intSelectedPtr),
        .granted(intSelected)
    );

    Picker #(
        .ENTRY_NUM(SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(SchedulerTypes::MEM_ISSUE_WIDTH)
    ) memPicker (
        .req(memRequest),
        .grant(memGrant),
        .grantPtr(memSelectedPtr),
        .granted(memSelected)
    );

    always_comb begin
        for (int g = 0; g < SchedulerTypes::INT_ISSUE_WIDTH; g++) begin
            laneMask = '0;
            for (int i = 0; i < SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM; i++) begin
                laneMask[i] = (i % SchedulerTypes::INT_ISSUE_WIDTH) == g;
            end
            port.selected[g] = intSelected[g] && !flushEntry[intSelectedPtr[g]];
            port.selectedPtr[g] = intSelectedPtr[g];
            port.selectedVector[g] = intGrant & laneMask & ~flushEntry;
        end

        // Memory lanes follow the integer lanes
        for (int m = 0; m < SchedulerTypes::MEM_ISSUE_WIDTH; m++) begin
            port.selected[m + SchedulerTypes::INT_ISSUE_WIDTH] =
                memSelected[m] && !flushEntry[memSelectedPtr[m]];
            port.selectedPtr[m + SchedulerTypes::INT_ISSUE_WIDTH] = memSelectedPtr[m];
            port.selectedVector[m + SchedulerTypes::INT_ISSUE_WIDTH] = memGrant & ~flushEntry;
        end
    end

endmodule : SelectLogic

// File: hdl/WakeupLogic.sv
// Wakeup side of the issue queue.
// Holds the entries, allocates the lowest free entry on dispatch, matches
// source tags against the integer issue broadcast and the external load
// wakeup, and reports which entries are ready to the select logic.
module WakeupLogic (
    input  logic clk,
    input  logic reset,
    input  logic dispatch,
    input  SchedulerTypes::OpClass dispatchClass,
    input  SchedulerTypes::PRegNumPath dispatchSrc0,
    input  SchedulerTypes::PRegNumPath dispatchSrc1,
    input  SchedulerTypes::PRegNumPath dispatchDst,
    input  logic dispatchSrc0Ready,
    input  logic dispatchSrc1Ready,
    input  logic extWakeup,
    input  SchedulerTypes::PRegNumPath extWakeupTag,
    input  SchedulerTypes::IssueQueueOneHotPath flushEntry,
    output logic dispatchFull,
    WakeupSelectIF.WakeupLogic port
);

    // Entry storage
    SchedulerTypes::IssueQueueOneHotPath valid;
    SchedulerTypes::OpClass opClass [SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM];
    SchedulerTypes::PRegNumPath src0Tag [SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM];
    SchedulerTypes::PRegNumPath src1Tag [SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM];
    SchedulerTypes::PRegNumPath dstTag [SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM];
    SchedulerTypes::IssueQueueOneHotPath src0Ready;
    SchedulerTypes::IssueQueueOneHotPath src1Ready;

    // Wakeup broadcast
    logic [SchedulerTypes::WAKEUP_NUM-1:0] wakeupValid;
    SchedulerTypes::PRegNumPath wakeupTag [SchedulerTypes::WAKEUP_NUM];
    SchedulerTypes::IssueQueueOneHotPath src0Match;
    SchedulerTypes::IssueQueueOneHotPath src1Match;
    logic dispatchSrc0Match;
    logic dispatchSrc1Match;

    // Allocation and release
    SchedulerTypes::IssueQueueOneHotPath freeGrant;
    SchedulerTypes::IssueQueueIndexPath freePtr [1];
    logic freeFound [1];
    logic dispatchAccept;
    SchedulerTypes::IssueQueueOneHotPath freed;

    Picker #(
        .ENTRY_NUM(SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM),
        .GRANT_NUM(1)
    ) freePicker (
        .req(~valid),
        .grant(freeGrant),
        .grantPtr(freePtr),
        .granted(freeFound)
    );

    assign dispatchFull = &valid;
    assign dispatchAccept = dispatch && freeFound[0];

    // Memory lanes never broadcast, only the integer lanes and loads do
    always_comb begin
        for (int k = 0; k < SchedulerTypes::INT_ISSUE_WIDTH; k++) begin
            wakeupValid[k] = port.issueValid[k];
            wakeupTag[k] = port.issueDstTag[k];
        end
        wakeupValid[SchedulerTypes::WAKEUP_NUM-1] = extWakeup;
        wakeupTag[SchedulerTypes::WAKEUP_NUM-1] = extWakeupTag;
    end

    always_comb begin
        src0Match = '0;
        src1Match = '0;
        dispatchSrc0Match = 1'b0;
        dispatchSrc1Match = 1'b0;
        for (int k = 0; k < SchedulerTypes::WAKEUP_NUM; k++) begin
            if (wakeupValid[k]) begin
                for (int i = 0; i < SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM; i++) begin
                    if (src0Tag[i] == wakeupTag[k]) begin
                        src0Match[i] = 1'b1;
                    end
                    if (src1Tag[i] == wakeupTag[k]) begin
                        src1Match[i] = 1'b1;
                    end
                end
                // Op being dispatched sees the same broadcast
                if (dispatchSrc0 == wakeupTag[k]) begin
                    dispatchSrc0Match = 1'b1;
                end
                if (dispatchSrc1 == wakeupTag[k]) begin
                    dispatchSrc1Match = 1'b1;
                end
            end
        end
    end

    // Same-cycle matches count, so a consumer issues right behind its producer
    always_comb begin
        for (int i = 0; i < SchedulerTypes::ISSUE_QUEUE_ENTRY_NUM; i++) begin
            port.opReady[i] = valid[i] && (src0Ready[i] || src0Match[i]) &&
                (src1Ready[i] || src1Match[i]);
            port.intIssueReq[i] = valid[i] && (opClass[i] == SchedulerTypes::OP_INT);
            port.memIssueReq[i] = valid[i] && (opClass[i] == SchedulerTypes::OP_MEM);
            port.entryDstTag[i] = dstTag[i];
        end
    end

    always_comb begin
        freed = '0;
        for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
            freed = freed | port.selectedVector[l];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else begin
            valid <= (valid & ~freed & ~flushEntry) | (dispatchAccept ? freeGrant : '0);
        end
    end

    always_ff @(posedge clk) begin
        src0Ready <= src0Ready | src0Match;
        src1Ready <= src1Ready | src1Match;
        if (dispatchAccept) begin
            opClass[freePtr[0]] <= dispatchClass;
            src0Tag[freePtr[0]] <= dispatchSrc0;
            src1Tag[freePtr[0]] <= dispatchSrc1;
            dstTag[freePtr[0]] <= dispatchDst;
            src0Ready[freePtr[0]] <= dispatchSrc0Ready || dispatchSrc0Match;
            src1Ready[freePtr[0]] <= dispatchSrc1Ready || dispatchSrc1Match;
        end
    end

endmodule : WakeupLogic

// File: hdl/WakeupPipelineRegister.sv
// Pipeline register between select and issue.
// Captures each lane's grant, entry index and destination tag, so a new
// selection forms while the previous one issues and broadcasts its tag.
module WakeupPipelineRegister (
    input  logic clk,
    input  logic reset,
    WakeupSelectIF.PipelineRegister port,
    output SchedulerTypes::IssueQueueIndexPath issuePtr [SchedulerTypes::ISSUE_WIDTH]
);

    SchedulerTypes::IssueLaneVector issueValidReg;
    SchedulerTypes::PRegNumPath issueDstTagReg [SchedulerTypes::ISSUE_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            issueValidReg <= '0;
        end else begin
            for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
                issueValidReg[l] <= port.selected[l];
            end
        end
    end

    // Tag is read from the entry now, since the entry is freed at this edge
    always_ff @(posedge clk) begin
        for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
            issuePtr[l] <= port.selectedPtr[l];
            issueDstTagReg[l] <= port.entryDstTag[port.selectedPtr[l]];
        end
    end

    assign port.issueValid = issueValidReg;
    assign port.issueDstTag = issueDstTagReg;

endmodule : WakeupPipelineRegister

// File: hdl/Scheduler.sv
// Top level of the wakeup and select stage of an eight-entry issue queue.
// Two interleaved integer lanes and one memory lane; issue results appear
// two cycles after dispatch at the earliest.
module Scheduler (
    input  logic clk,
    input  logic reset,
    input  logic dispatch,
    input  SchedulerTypes::OpClass dispatchClass,
    input  SchedulerTypes::PRegNumPath dispatchSrc0,
    input  SchedulerTypes::PRegNumPath dispatchSrc1,
    input  SchedulerTypes::PRegNumPath dispatchDst,
    input  logic dispatchSrc0Ready,
    input  logic dispatchSrc1Ready,
    input  logic extWakeup,
    input  SchedulerTypes::PRegNumPath extWakeupTag,
    input  SchedulerTypes::IssueQueueOneHotPath flushEntry,
    output logic dispatchFull,
    output SchedulerTypes::IssueLaneVector issueValid,
    output SchedulerTypes::IssueQueueIndexPath [SchedulerTypes::ISSUE_WIDTH-1:0] issuePtr,
    output SchedulerTypes::PRegNumPath [SchedulerTypes::ISSUE_WIDTH-1:0] issueDstTag
);

    WakeupSelectIF wakeupSelect ();

    SchedulerTypes::IssueQueueIndexPath issuePtrLane [SchedulerTypes::ISSUE_WIDTH];

    WakeupLogic wakeupLogic (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .dispatchClass(dispatchClass),
        .dispatchSrc0(dispatchSrc0),
        .dispatchSrc1(dispatchSrc1),
        .dispatchDst(dispatchDst),
        .dispatchSrc0Ready(dispatchSrc0Ready),
        .dispatchSrc1Ready(dispatchSrc1Ready),
        .extWakeup(extWakeup),
        .extWakeupTag(extWakeupTag),
        .flushEntry(flushEntry),
        .dispatchFull(dispatchFull),
        .port(wakeupSelect)
    );

    SelectLogic selectLogic (
        .port(wakeupSelect),
        .flushEntry(flushEntry)
    );

    WakeupPipelineRegister pipelineRegister (
        .clk(clk),
        .reset(reset),
        .port(wakeupSelect),
        .issuePtr(issuePtrLane)
    );

    // Pack the lanes for the external ports
    always_comb begin
        for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
            issuePtr[l] = issuePtrLane[l];
            issueDstTag[l] = wakeupSelect.issueDstTag[l];
        end
    end

    assign issueValid = wakeupSelect.issueValid;

endmodule : Scheduler

// File: verif/Scheduler_asserts.sv
// Concurrent checks on the scheduler issue outputs.
// Bound into every Scheduler instance.
module SchedulerAsserts (
    input logic clk,
    input logic reset,
    input SchedulerTypes::IssueQueueOneHotPath flushEntry,
    input SchedulerTypes::IssueLaneVector issueValid,
    input SchedulerTypes::IssueQueueIndexPath [SchedulerTypes::ISSUE_WIDTH-1:0] issuePtr
);

    SchedulerTypes::IssueQueueOneHotPath issuedEntries;

    always_comb begin
        issuedEntries = '0;
        for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
            if (issueValid[l]) begin
                issuedEntries[issuePtr[l]] = 1'b1;
            end
        end
    end

    // One distinct entry per issuing lane
    assert property (@(posedge clk) disable iff (reset)
        $countones(issuedEntries) == $countones(issueValid))
        else $error("two lanes issued the same entry");

    assert property (@(posedge clk) $past(reset) && !reset |-> issueValid == '0)
        else $error("issue right after reset");

    assert property (@(posedge clk) disable iff (reset)
        (issuedEntries & $past(flushEntry)) == '0)
        else $error("flushed entry issued");

endmodule : SchedulerAsserts

bind Scheduler SchedulerAsserts schedulerAsserts (
    .clk(clk),
    .reset(reset),
    .flushEntry(flushEntry),
    .issueValid(issueValid),
    .issuePtr(issuePtr)
);

// File: verif/SchedulerTests.svh
// Directed tests for the scheduler, included inside the testbench module.
// Each test starts and ends with an empty issue queue.

task automatic testReadyDispatch();
    int tags [4] = '{10, 11, 12, 13};
    int expEntry [4] = '{0, 1, 0, 1};
    int expLane [4] = '{0, 1, 2, 1};
    clearLog();
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 0, 1, 10, 1'b1, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 2, 3, 11, 1'b1, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_MEM, 1, 2, 12, 1'b1, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 3, 0, 13, 1'b1, 1'b1);
    waitIssued(13, 10);
    for (int i = 0; i < 4; i++) begin
        checkValue("issueLatency", issueEdge[tags[i]] - dispEdge[tags[i]], 2);
        checkValue("issuePtr", issueEntry[tags[i]], expEntry[i]);
        checkValue("issueLane", issueLane[tags[i]], expLane[i]);
    end
endtask

task automatic testDependencyChain();
    clearLog();
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 0, 1, 14, 1'b1, 1'b1);
    for (int i = 15; i < 18; i++) begin
        nextCycle();
        putOp(SchedulerTypes::OP_INT, i - 1, 0, i, 1'b0, 1'b1);
    end
    waitIssued(17, 12);
    checkValue("issueLatency", issueEdge[14] - dispEdge[14], 2);
    for (int i = 15; i < 18; i++) begin
        checkValue("chainInterval", issueEdge[i] - issueEdge[i - 1], 1);
    end
endtask

task automatic testExternalWakeup();
    int pulseEdge;
    clearLog();
    nextCycle();
    putOp(SchedulerTypes::OP_MEM, 19, 0, 18, 1'b0, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 18, 0, 20, 1'b0, 1'b1);
    repeat (4) nextCycle();
    checkValue("issuedCount", issuedCount[18] + issuedCount[20], 0);
    nextCycle();
    pulseWakeup(19);
    pulseEdge = cycle;
    waitIssued(18, 6);
    checkValue("wakeupLatency", issueEdge[18] - pulseEdge, 1);
    checkValue("issueLane", issueLane[18], 2);
    // Load tag is not broadcast by the memory lane
    repeat (4) nextCycle();
    checkValue("issuedCount", issuedCount[20], 0);
    nextCycle();
    pulseWakeup(18);
    pulseEdge = cycle;
    waitIssued(20, 6);
    checkValue("wakeupLatency", issueEdge[20] - pulseEdge, 1);
endtask

task automatic testFullQueue();
    int pulseEdge;
    clearLog();
    for (int i = 0; i < 8; i++) begin
        nextCycle();
        putOp(SchedulerTypes::OP_INT, 21, 0, 22 + i, 1'b0, 1'b1);
    end
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 0, 1, 30, 1'b1, 1'b1);
    @(negedge clk);
    checkValue("dispatchFull", 32'(dispatchFull), 1);
    repeat (3) nextCycle();
    nextCycle();
    pulseWakeup(21);
    pulseEdge = cycle;
    // Two integer lanes, so entries 2k and 2k+1 go together
    for (int i = 0; i < 8; i++) begin
        waitIssued(22 + i, 10);
        checkValue("issueEdge", issueEdge[22 + i] - pulseEdge, 1 + i / 2);
    end
    @(negedge clk);
    checkValue("dispatchFull", 32'(dispatchFull), 0);
    repeat (4) nextCycle();
    checkValue("issuedCount", issuedCount[30], 0);
endtask

task automatic testFlush();
    int pulseEdge;
    clearLog();
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 9, 0, 8, 1'b0, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 9, 0, 10, 1'b0, 1'b1);
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 0, 1, 11, 1'b1, 1'b1);
    // Entry 0 waits, entry 2 is being selected right now
    nextCycle();
    flushEntries(8'b0000_0101);
    flushed[8] = 1'b1;
    flushed[11] = 1'b1;
    nextCycle();
    putOp(SchedulerTypes::OP_INT, 0, 2, 12, 1'b1, 1'b1);
    nextCycle();
    pulseWakeup(9);
    pulseEdge = cycle;
    waitIssued(10, 6);
    waitIssued(12, 6);
    checkValue("wakeupLatency", issueEdge[10] - pulseEdge, 1);
    checkValue("issueLatency", issueEdge[12] - dispEdge[12], 2);
    repeat (4) nextCycle();
    checkValue("issuedCount", issuedCount[8] + issuedCount[11], 0);
endtask

task automatic testRandomTraffic();
    int s0;
    int s1;
    logic isMem;
    clearLog();
    // Eight ops always fit, so nothing is dropped
    for (int n = 0; n < 8; n++) begin
        nextCycle();
        if (n % 3 == 2) begin
            pulseWakeup(4 + n / 3);
        end
        s0 = {$random(seed)} % 8;
        s1 = {$random(seed)} % 8;
        isMem = ($random(seed) % 2) != 0;
        putOp(isMem ? SchedulerTypes::OP_MEM : SchedulerTypes::OP_INT, s0, s1, 8 + n,
              tagReady[s0], tagReady[s1]);
    end
    for (int t = 4; t < 8; t++) begin
        nextCycle();
        pulseWakeup(t);
    end
    for (int n = 0; n < 8; n++) begin
        waitIssued(8 + n, 20);
    end
    repeat (4) nextCycle();
    for (int n = 0; n < 8; n++) begin
        checkValue("issuedCount", issuedCount[8 + n], 1);
    end
endtask

// File: verif/SchedulerTb.sv
// Testbench for the issue queue scheduler.
// Drives dispatch, external wakeup and flush, logs every issue against a model
// of ready tags and pending ops, and runs the directed tests from SchedulerTests.svh.
module SchedulerTb;

    localparam int TOTAL_OPS = 31;
    localparam int TAG_NUM = SchedulerTypes::PHY_REG_NUM;

    logic clk;
    logic reset;
    logic dispatch;
    SchedulerTypes::OpClass dispatchClass;
    SchedulerTypes::PRegNumPath dispatchSrc0;
    SchedulerTypes::PRegNumPath dispatchSrc1;
    SchedulerTypes::PRegNumPath dispatchDst;
    logic dispatchSrc0Ready;
    logic dispatchSrc1Ready;
    logic extWakeup;
    SchedulerTypes::PRegNumPath extWakeupTag;
    SchedulerTypes::IssueQueueOneHotPath flushEntry;
    logic dispatchFull;
    SchedulerTypes::IssueLaneVector issueValid;
    SchedulerTypes::IssueQueueIndexPath [SchedulerTypes::ISSUE_WIDTH-1:0] issuePtr;
    SchedulerTypes::PRegNumPath [SchedulerTypes::ISSUE_WIDTH-1:0] issueDstTag;

    // Model state, indexed by destination tag
    logic tagReady [TAG_NUM];
    logic dispatched [TAG_NUM];
    logic flushed [TAG_NUM];
    logic opIsMem [TAG_NUM];
    int opSrc0 [TAG_NUM];
    int opSrc1 [TAG_NUM];
    int dispEdge [TAG_NUM];
    int issueEdge [TAG_NUM];
    int issueLane [TAG_NUM];
    int issueEntry [TAG_NUM];
    int issuedCount [TAG_NUM];

    // Number of falling edges so far, equal to the index of the next rising edge
    int cycle = 0;
    int seed = 32'h427a_ccb6;

    Scheduler u_Scheduler (
        .clk(clk),
        .reset(reset),
        .dispatch(dispatch),
        .dispatchClass(dispatchClass),
        .dispatchSrc0(dispatchSrc0),
        .dispatchSrc1(dispatchSrc1),
        .dispatchDst(dispatchDst),
        .dispatchSrc0Ready(dispatchSrc0Ready),
        .dispatchSrc1Ready(dispatchSrc1Ready),
        .extWakeup(extWakeup),
        .extWakeupTag(extWakeupTag),
        .flushEntry(flushEntry),
        .dispatchFull(dispatchFull),
        .issueValid(issueValid),
        .issuePtr(issuePtr),
        .issueDstTag(issueDstTag)
    );

    task automatic abortRun();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            abortRun();
        end
    endtask

    // Tags 0 to 3 count as ready from the start
    task automatic clearLog();
        for (int t = 0; t < TAG_NUM; t++) begin
            tagReady[t] = (t < 4);
            dispatched[t] = 1'b0;
            flushed[t] = 1'b0;
            opIsMem[t] = 1'b0;
            issuedCount[t] = 0;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        dispatch <= 1'b0;
        extWakeup <= 1'b0;
        flushEntry <= '0;
    endtask

    task automatic putOp(SchedulerTypes::OpClass cls, int s0, int s1, int dst,
                         logic r0, logic r1);
        dispatch <= 1'b1;
        dispatchClass <= cls;
        dispatchSrc0 <= SchedulerTypes::PRegNumPath'(s0);
        dispatchSrc1 <= SchedulerTypes::PRegNumPath'(s1);
        dispatchDst <= SchedulerTypes::PRegNumPath'(dst);
        dispatchSrc0Ready <= r0;
        dispatchSrc1Ready <= r1;
        dispatched[dst] = 1'b1;
        opIsMem[dst] = (cls == SchedulerTypes::OP_MEM);
        opSrc0[dst] = s0;
        opSrc1[dst] = s1;
        dispEdge[dst] = cycle;
    endtask

    task automatic pulseWakeup(int tag);
        extWakeup <= 1'b1;
        extWakeupTag <= SchedulerTypes::PRegNumPath'(tag);
        tagReady[tag] = 1'b1;
    endtask

    task automatic flushEntries(SchedulerTypes::IssueQueueOneHotPath mask);
        flushEntry <= mask;
    endtask

    task automatic waitIssued(int tag, int limit);
        int n;
        n = 0;
        while (issuedCount[tag] == 0 && n < limit) begin
            nextCycle();
            n++;
        end
        if (issuedCount[tag] == 0) begin
            $display("Op with destination tag %0d did not issue within %0d cycles", tag, limit);
            abortRun();
        end
    endtask

    task automatic noteIssue(int lane, int ptr, int tag);
        if (!dispatched[tag]) begin
            $display("Op with destination tag %0d issued but was never dispatched", tag);
            abortRun();
        end
        if (flushed[tag]) begin
            $display("Op with destination tag %0d issued after it was flushed", tag);
            abortRun();
        end
        checkValue("issuedCount", issuedCount[tag], 0);
        checkValue("src0Ready", 32'(tagReady[opSrc0[tag]]), 1);
        checkValue("src1Ready", 32'(tagReady[opSrc1[tag]]), 1);
        // Interleaved integer lanes, single memory lane
        checkValue("issueLane", lane, opIsMem[tag] ? 2 : ptr % 2);
        issuedCount[tag]++;
        issueEdge[tag] = cycle - 1;
        issueLane[tag] = lane;
        issueEntry[tag] = ptr;
    endtask

    // Check all lanes first, then wake, so same-cycle issues never satisfy each other
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (!reset) begin
            for (int l = 0; l < SchedulerTypes::ISSUE_WIDTH; l++) begin
                if (issueValid[l]) begin
                    noteIssue(l, int'(issuePtr[l]), int'(issueDstTag[l]));
                end
            end
            for (int l = 0; l < SchedulerTypes::INT_ISSUE_WIDTH; l++) begin
                if (issueValid[l]) begin
                    tagReady[issueDstTag[l]] = 1'b1;
                end
            end
        end
    end

    `include "SchedulerTests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (20 * TOTAL_OPS + 4) @(posedge clk);
        $display("Timeout: the run went past %0d cycles", 20 * TOTAL_OPS + 4);
        abortRun();
    end

    initial begin
        reset = 1'b1;
        dispatch = 1'b0;
        dispatchClass = SchedulerTypes::OP_INT;
        dispatchSrc0 = '0;
        dispatchSrc1 = '0;
        dispatchDst = '0;
        dispatchSrc0Ready = 1'b0;
        dispatchSrc1Ready = 1'b0;
        extWakeup = 1'b0;
        extWakeupTag = '0;
        flushEntry = '0;
        clearLog();
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        testReadyDispatch();
        testDependencyChain();
        testExternalWakeup();
        testFullQueue();
        testFlush();
        testRandomTraffic();

        repeat (4) nextCycle();
        $display("NO ERRORS");
        $finish;
    end

endmodule : SchedulerTb

// File: build.f
+incdir+verif
hdl/SchedulerTypes.sv
hdl/WakeupSelectIF.sv
hdl/Picker.sv
hdl/InterleavedPicker.sv
hdl/SelectLogic.sv
hdl/WakeupLogic.sv
hdl/WakeupPipelineRegister.sv
hdl/Scheduler.sv
verif/Scheduler_asserts.sv
verif/SchedulerTb.sv

// File: Makefile
TOP = SchedulerTb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f hdl/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
